/* hw/noc_flit_pkg.sv */
`default_nettype none

package noc_flit_pkg;

        localparam int COORD_W   = 2;   // Enough for a 4 by 4 mesh.
        localparam int PAYLOAD_W = 16;

        typedef logic [COORD_W-1:0]   coord_t;
        typedef logic [PAYLOAD_W-1:0] payload_t;

        // Position of a flit within its packet.
        typedef enum logic [1:0] {
                head     = 2'b00,
                body     = 2'b01,
                tail     = 2'b10,
                headtail = 2'b11        // A packet of a single flit.
        } flit_type_t;

        // Body and tail flits repeat the destination, but only the head's copy is routed.
        typedef struct packed {
                flit_type_t ftype;
                coord_t     dst_x;
                coord_t     dst_y;
                payload_t   payload;
        } flit_t;

endpackage

`default_nettype wire

/* hw/noc_router_pkg.sv */
`default_nettype none

package noc_router_pkg;

        localparam int NUM_VC    = 2;
        localparam int NUM_PORTS = 5;

        typedef logic [$clog2(NUM_VC)-1:0] vc_id_t;
        typedef logic [NUM_VC-1:0]         vc_mask_t;   // One bit per virtual channel.

        // East points toward growing X and north toward growing Y.
        typedef enum logic [2:0] {
                port_local = 3'd0,
                port_east  = 3'd1,
                port_west  = 3'd2,
                port_north = 3'd3,
                port_south = 3'd4
        } port_t;

        typedef enum logic [1:0] {
                rc_stage  = 2'b00,      // Routing computation.
                vsa_stage = 2'b01,      // VC and switch allocation.
                st_stage  = 2'b10       // Switch traversal.
        } vc_state_t;

        // What one output port carries toward the next router.
        typedef struct packed {
                logic                valid;
                vc_id_t              vc;
                noc_flit_pkg::flit_t flit;
        } out_flit_t;

endpackage

`default_nettype wire

/* hw/vc_flit_buffer.sv */
`default_nettype none

module vc_flit_buffer #(
        parameter int DEPTH = 4
) (
        input  logic                clk,
        input  logic                reset,
        input  logic                push,
        input  noc_flit_pkg::flit_t push_flit,
        input  logic                pop,
        output noc_flit_pkg::flit_t head_flit,
        output logic                empty,
        output logic                full
);

        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CNT_W = $clog2(DEPTH + 1);

        noc_flit_pkg::flit_t mem [DEPTH];
        logic [PTR_W-1:0]    rd_ptr;
        logic [PTR_W-1:0]    wr_ptr;
        logic [CNT_W-1:0]    count;
        logic                do_push;
        logic                do_pop;

        assign do_push   = push && !full;       // A push into a full buffer is lost.
        assign do_pop    = pop && !empty;
        assign empty     = (count == '0);
        assign full      = (count == CNT_W'(DEPTH));
        assign head_flit = mem[rd_ptr];         // Oldest flit, shown without a read cycle.

        always_ff @(posedge clk) begin
                if (do_push) begin
                        mem[wr_ptr] <= push_flit;
                end
        end

        // Pointers wrap explicitly so that any depth works.
        always_ff @(posedge clk) begin
                if (reset) begin
                        rd_ptr <= '0;
                        wr_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_push) begin
                                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (do_pop) begin
                                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        end
                        case ({do_push, do_pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;  // Both or neither leave the level.
                        endcase
                end
        end

endmodule

`default_nettype wire

/* hw/xy_route_calc.sv */
`default_nettype none

module xy_route_calc #(
        parameter noc_flit_pkg::coord_t ROUTER_X = '0,
        parameter noc_flit_pkg::coord_t ROUTER_Y = '0
) (
        input  logic                  clk,
        input  logic                  reset,
        input  noc_flit_pkg::flit_t   head_flit,
        input  logic                  capture,
        output noc_router_pkg::port_t port
);

        noc_router_pkg::port_t next_port;

        // Dimension-ordered routing. X is resolved completely before Y.
        always_comb begin
                if (head_flit.dst_x > ROUTER_X) begin
                        next_port = noc_router_pkg::port_east;
                end else if (head_flit.dst_x < ROUTER_X) begin
                        next_port = noc_router_pkg::port_west;
                end else if (head_flit.dst_y > ROUTER_Y) begin
                        next_port = noc_router_pkg::port_north;
                end else if (head_flit.dst_y < ROUTER_Y) begin
                        next_port = noc_router_pkg::port_south;
                end else begin
                        next_port = noc_router_pkg::port_local;  // Packet has arrived.
                end
        end

        // The port is kept until the next head is captured, so body and
        // tail flits follow the head without looking at their own copy.
        always_ff @(posedge clk) begin
                if (reset) begin
                        port <= noc_router_pkg::port_local;
                end else if (capture) begin
                        port <= next_port;
                end
        end

endmodule

`default_nettype wire

/* hw/vc_ctrl.sv */
`default_nettype none

module vc_ctrl (
        input  logic                                                       clk,
        input  logic                                                       reset,
        input  noc_flit_pkg::flit_t                                        head_flit,
        input  logic                                                       empty,
        input  noc_router_pkg::port_t                                      port,
        input  noc_router_pkg::vc_id_t                                     ovch,
        input  noc_router_pkg::vc_mask_t [noc_router_pkg::NUM_PORTS-1:0]   out_rdy,
        input  noc_router_pkg::vc_mask_t [noc_router_pkg::NUM_PORTS-1:0]   out_lck,
        input  logic [noc_router_pkg::NUM_PORTS-1:0]                       grt,
        output logic                                                       req,
        output logic                                                       send,
        output logic                                                       pop,
        output logic                                                       capture,
        output logic                                                       olck
);

        noc_router_pkg::vc_state_t state;
        logic                      is_head;
        logic                      is_tail;
        logic                      rdy;     // Next VC can take a flit.
        logic                      lck;     // Next VC is held by another input.
        logic                      grt_sel; // Switch port is ours.

        assign is_head = !empty && (head_flit.ftype == noc_flit_pkg::head ||
                                    head_flit.ftype == noc_flit_pkg::headtail);
        assign is_tail = (head_flit.ftype == noc_flit_pkg::tail ||
                          head_flit.ftype == noc_flit_pkg::headtail);

        // Only the bits of the routed port and output VC matter.
        assign rdy     = out_rdy[port][ovch];
        assign lck     = out_lck[port][ovch];
        assign grt_sel = grt[port];

        assign olck    = (state != noc_router_pkg::rc_stage);
        assign capture = (state == noc_router_pkg::rc_stage) && is_head;

        // A flit crosses the switch whenever traversal has a flit and a free downstream slot.
        assign send = (state == noc_router_pkg::st_stage) && !empty && rdy && grt_sel;
        assign pop  = send;     // Every flit sent leaves the buffer in the same cycle.

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= noc_router_pkg::rc_stage;
                        req   <= 1'b0;
                end else begin
                        case (state)
                                noc_router_pkg::rc_stage: begin
                                        if (is_head) begin
                                                state <= noc_router_pkg::vsa_stage;
                                                req   <= 1'b1;
                                        end
                                end
                                noc_router_pkg::vsa_stage: begin
                                        if (lck) begin
                                                // Back off until the next VC is freed.
                                                req <= 1'b0;
                                        end else if (grt_sel && rdy) begin
                                                state <= noc_router_pkg::st_stage;
                                                req   <= 1'b1;
                                        end else begin
                                                req <= 1'b1;
                                        end
                                end
                                noc_router_pkg::st_stage: begin
                                        // The request stays up so the switch keeps the grant.
                                        if (pop && is_tail) begin
                                                state <= noc_router_pkg::rc_stage;
                                                req   <= 1'b0;
                                        end
                                end
                                default: begin
                                        state <= noc_router_pkg::rc_stage;
                                        req   <= 1'b0;
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

/* hw/switch_port.sv */
`default_nettype none

module switch_port #(
        parameter noc_router_pkg::port_t PORT_ID = noc_router_pkg::port_local
) (
        input  logic                                                    clk,
        input  logic                                                    reset,
        input  noc_router_pkg::vc_mask_t                                req,
        input  noc_router_pkg::port_t [noc_router_pkg::NUM_VC-1:0]      port,
        input  noc_router_pkg::vc_mask_t                                pop,
        input  noc_flit_pkg::flit_t [noc_router_pkg::NUM_VC-1:0]        head_flit,
        output noc_router_pkg::vc_mask_t                                grt,
        output noc_router_pkg::out_flit_t                               out_flit
);

        noc_router_pkg::vc_mask_t req_here;     // Requests aimed at this port.
        noc_router_pkg::vc_id_t   owner;
        noc_router_pkg::vc_id_t   last;         // Most recent winner, for rotation.
        noc_router_pkg::vc_id_t   pick;
        logic                     pick_ok;
        logic                     owner_tail;

        always_comb begin
                for (int v = 0; v < noc_router_pkg::NUM_VC; v++) begin
                        req_here[v] = req[v] && (port[v] == PORT_ID);
                end
        end

        always_comb begin
                owner = '0;
                for (int v = 0; v < noc_router_pkg::NUM_VC; v++) begin
                        if (grt[v]) owner = noc_router_pkg::vc_id_t'(v);
                end
        end

        // Search starts just after the last winner; the nearest requester wins.
        always_comb begin
                int idx;
                pick    = last;
                pick_ok = 1'b0;
                for (int k = noc_router_pkg::NUM_VC; k >= 1; k--) begin
                        idx = (int'(last) + k) % noc_router_pkg::NUM_VC;
                        if (req_here[idx]) begin
                                pick    = noc_router_pkg::vc_id_t'(idx);
                                pick_ok = 1'b1;
                        end
                end
        end

        assign owner_tail = pop[owner] &&
                            (head_flit[owner].ftype == noc_flit_pkg::tail ||
                             head_flit[owner].ftype == noc_flit_pkg::headtail);

        // A grant lasts a whole packet, so two VCs never interleave on this port.
        always_ff @(posedge clk) begin
                if (reset) begin
                        grt  <= '0;
                        last <= '0;
                end else if (grt != '0) begin
                        if (owner_tail || !req_here[owner]) grt <= '0;
                end else if (pick_ok) begin
                        grt  <= noc_router_pkg::vc_mask_t'(1) << pick;
                        last <= pick;
                end
        end

        always_comb begin
                out_flit.valid = |(grt & pop);
                out_flit.vc    = owner;   // Output VC equals input VC.
                out_flit.flit  = head_flit[owner];
        end

endmodule

`default_nettype wire

/* hw/router_input_unit.sv */
`default_nettype none

module router_input_unit #(
        parameter noc_flit_pkg::coord_t ROUTER_X  = '0,
        parameter noc_flit_pkg::coord_t ROUTER_Y  = '0,
        parameter int                   BUF_DEPTH = 4
) (
        input  logic                                                       clk,
        input  logic                                                       reset,
        input  logic                                                       in_valid,
        input  noc_router_pkg::vc_id_t                                     in_vc,
        input  noc_flit_pkg::flit_t                                        in_flit,
        output noc_router_pkg::vc_mask_t                                   buf_full,
        input  noc_router_pkg::vc_mask_t [noc_router_pkg::NUM_PORTS-1:0]   out_rdy,
        input  noc_router_pkg::vc_mask_t [noc_router_pkg::NUM_PORTS-1:0]   out_lck,
        output noc_router_pkg::vc_mask_t                                   olck,
        output noc_router_pkg::out_flit_t [noc_router_pkg::NUM_PORTS-1:0]  out_flit
);

        noc_flit_pkg::flit_t [noc_router_pkg::NUM_VC-1:0]      head_flit;
        noc_router_pkg::port_t [noc_router_pkg::NUM_VC-1:0]    vc_port;
        noc_router_pkg::vc_mask_t                              buf_empty;
        noc_router_pkg::vc_mask_t                              vc_req;
        noc_router_pkg::vc_mask_t                              vc_send;
        noc_router_pkg::vc_mask_t                              vc_pop;
        noc_router_pkg::vc_mask_t                              vc_capture;
        noc_router_pkg::vc_mask_t [noc_router_pkg::NUM_PORTS-1:0] port_grt; // Per port, per VC.
        logic [noc_router_pkg::NUM_PORTS-1:0]                  vc_grt [noc_router_pkg::NUM_VC];

        for (genvar v = 0; v < noc_router_pkg::NUM_VC; v++) begin : g_vc
                vc_flit_buffer #(.DEPTH(BUF_DEPTH)) fifo_i (
                        .clk(clk), .reset(reset),
                        .push(in_valid && (in_vc == noc_router_pkg::vc_id_t'(v))),
                        .push_flit(in_flit), .pop(vc_pop[v]), .head_flit(head_flit[v]),
                        .empty(buf_empty[v]), .full(buf_full[v]));

                xy_route_calc #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) route_i (
                        .clk(clk), .reset(reset), .head_flit(head_flit[v]),
                        .capture(vc_capture[v]), .port(vc_port[v]));

                vc_ctrl ctrl_i (
                        .clk(clk), .reset(reset), .head_flit(head_flit[v]),
                        .empty(buf_empty[v]), .port(vc_port[v]),
                        .ovch(noc_router_pkg::vc_id_t'(v)), .out_rdy(out_rdy),
                        .out_lck(out_lck), .grt(vc_grt[v]), .req(vc_req[v]),
                        .send(vc_send[v]), .pop(vc_pop[v]), .capture(vc_capture[v]),
                        .olck(olck[v]));

                // Each controller sees the grants of all ports for its own VC.
                for (genvar p = 0; p < noc_router_pkg::NUM_PORTS; p++) begin : g_grt
                        assign vc_grt[v][p] = port_grt[p][v];
                end
        end

        for (genvar p = 0; p < noc_router_pkg::NUM_PORTS; p++) begin : g_port
                switch_port #(.PORT_ID(noc_router_pkg::port_t'(p))) sw_i (
                        .clk(clk), .reset(reset), .req(vc_req), .port(vc_port),
                        .pop(vc_send), .head_flit(head_flit), .grt(port_grt[p]),
                        .out_flit(out_flit[p]));
        end

endmodule

`default_nettype wire

/* dv/router_input_unit_assertions.sv */
`default_nettype none

module router_input_unit_assertions (
        input logic                      clk,
        input logic                      reset,
        input logic                      olck,
        input logic                      capture,
        input logic                      pop,
        input logic                      tail,
        input noc_router_pkg::vc_mask_t  req,
        input noc_router_pkg::vc_mask_t  grt
);

        timeunit 1ns;
        timeprecision 1ps;

        // A granted VC asked for this port in the cycle before.
        grant_follows_request: assert property (@(posedge clk) disable iff (reset)
                (grt != '0) |-> (($past(req) & grt) == grt))
                else $error("Switch port granted a VC that was not requesting it.");

        olck_starts_at_head: assert property (@(posedge clk) disable iff (reset)
                $rose(olck) |-> $past(capture))
                else $error("olck rose without a head flit being routed.");

        // The VC stays locked until its tail has left the buffer.
        olck_ends_at_tail: assert property (@(posedge clk) disable iff (reset)
                $fell(olck) |-> $past(pop && tail))
                else $error("olck fell before the tail flit left.");

endmodule

// The controller has no request or grant vector of its own.
bind vc_ctrl router_input_unit_assertions ctrl_checks_i (
        .clk(clk), .reset(reset), .olck(olck), .capture(capture), .pop(pop),
        .tail(is_tail), .req('0), .grt('0));

// The switch port has no controller lock or buffer, so those inputs sit idle.
bind switch_port router_input_unit_assertions port_checks_i (
        .clk(clk), .reset(reset), .olck(1'b0), .capture(1'b0), .pop(1'b0),
        .tail(1'b0), .req(req_here), .grt(grt));

`default_nettype wire

/* dv/router_input_unit_tb.sv */
`default_nettype none

module router_input_unit_tb;

        timeunit 1ns;
        timeprecision 1ps;

        localparam noc_flit_pkg::coord_t ROUTER_X = 2'd1;
        localparam noc_flit_pkg::coord_t ROUTER_Y = 2'd1;
        localparam int BUF_DEPTH   = 4;
        localparam int NUM_PORTS   = noc_router_pkg::NUM_PORTS;
        localparam int NUM_VC      = noc_router_pkg::NUM_VC;
        localparam int NUM_SWEEP   = 16;        // One packet to each node of the 4 by 4 mesh.
        localparam int NUM_RANDOM  = 80;
        localparam int NUM_LOCKED  = 6;
        localparam int MAX_FLITS   = 4 * (NUM_SWEEP + NUM_RANDOM + NUM_LOCKED);
        localparam int CYCLE_LIMIT = 40 * MAX_FLITS + 200;
        localparam int DRAIN_LIMIT = 40 * NUM_VC * BUF_DEPTH + 200;  // Only buffered flits remain.

        // Where a flit must leave the router and what it must carry.
        typedef struct packed {
                noc_router_pkg::port_t  port;
                noc_router_pkg::vc_id_t vc;
                noc_flit_pkg::flit_t    flit;
        } expected_t;

        logic                                      clk = 1'b0;
        logic                                      reset = 1'b1;
        logic                                      in_valid = 1'b0;
        noc_router_pkg::vc_id_t                    in_vc = '0;
        noc_flit_pkg::flit_t                       in_flit = '0;
        noc_router_pkg::vc_mask_t                  buf_full;
        noc_router_pkg::vc_mask_t [NUM_PORTS-1:0]  out_rdy = '1;
        noc_router_pkg::vc_mask_t [NUM_PORTS-1:0]  out_lck = '0;
        noc_router_pkg::vc_mask_t                  olck;
        noc_router_pkg::out_flit_t [NUM_PORTS-1:0] out_flit;

        expected_t                exp_q [NUM_VC][$];
        logic                     random_rdy = 1'b0;    // Random downstream stalls.
        logic [NUM_PORTS-1:0]     pkt_open = '0;        // A packet is mid-way through a port.
        noc_router_pkg::vc_id_t   open_vc [NUM_PORTS];
        noc_router_pkg::vc_mask_t tail_seen = '0;
        logic [8:0]               flit_serial = '0;
        int                       cycles = 0;

        router_input_unit #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y), .BUF_DEPTH(BUF_DEPTH)) dut_i (
                .clk(clk), .reset(reset), .in_valid(in_valid), .in_vc(in_vc),
                .in_flit(in_flit), .buf_full(buf_full), .out_rdy(out_rdy), .out_lck(out_lck),
                .olck(olck), .out_flit(out_flit));

        always #5 clk = ~clk;

        // XY routing: settle X first, then Y, and deliver locally when both match.
        function automatic noc_router_pkg::port_t xy_port(noc_flit_pkg::coord_t x,
                                                          noc_flit_pkg::coord_t y);
                if (x > ROUTER_X) return noc_router_pkg::port_east;
                if (x < ROUTER_X) return noc_router_pkg::port_west;
                if (y > ROUTER_Y) return noc_router_pkg::port_north;
                if (y < ROUTER_Y) return noc_router_pkg::port_south;
                return noc_router_pkg::port_local;
        endfunction

        function automatic int pending_flits();
                int n;
                n = 0;
                for (int v = 0; v < NUM_VC; v++) n += exp_q[v].size();
                return n;
        endfunction

        task automatic abort_run(string why);
                $display("%s", why);
                $display("Test failed");
                $fatal(1, "Stopped at the first error.");
        endtask

        task automatic check_flit(string name, noc_flit_pkg::flit_t expected,
                                  noc_flit_pkg::flit_t actual);
                if (actual !== expected) begin
                        abort_run($sformatf("Fail %s: expected %h, got %h",
                                            name, expected, actual));
                end
        endtask

        task automatic check_port(string name, noc_router_pkg::port_t expected,
                                  noc_router_pkg::port_t actual);
                if (actual !== expected) begin
                        abort_run($sformatf("Fail %s: expected %h, got %h",
                                            name, expected, actual));
                end
        endtask

        task automatic check_vc(string name, noc_router_pkg::vc_id_t expected,
                                noc_router_pkg::vc_id_t actual);
                if (actual !== expected) begin
                        abort_run($sformatf("Fail %s: expected %h, got %h",
                                            name, expected, actual));
                end
        endtask

        task automatic check_full(string name, noc_router_pkg::vc_mask_t expected,
                                  noc_router_pkg::vc_mask_t actual);
                if (actual !== expected) begin
                        abort_run($sformatf("Fail %s: expected %h, got %h",
                                            name, expected, actual));
                end
        endtask

        // Called on a falling edge. A flit waits while its buffer reports full.
        task automatic send_packet(noc_router_pkg::vc_id_t vc, int len,
                                   noc_flit_pkg::coord_t dx, noc_flit_pkg::coord_t dy);
                expected_t e;
                e.port = xy_port(dx, dy);
                e.vc   = vc;
                for (int i = 0; i < len; i++) begin
                        e.flit.ftype   = (len == 1)     ? noc_flit_pkg::headtail :
                                         (i == 0)       ? noc_flit_pkg::head :
                                         (i == len - 1) ? noc_flit_pkg::tail : noc_flit_pkg::body;
                        e.flit.dst_x   = dx;
                        e.flit.dst_y   = dy;
                        e.flit.payload = {flit_serial, 7'($urandom)};  // Unique in every flit.
                        flit_serial    = flit_serial + 1'b1;
                        while (buf_full[vc]) begin
                                in_valid = 1'b0;
                                @(negedge clk);
                        end
                        in_valid = 1'b1;
                        in_vc    = vc;
                        in_flit  = e.flit;
                        exp_q[vc].push_back(e);
                        @(negedge clk);
                end
                in_valid = 1'b0;
        endtask

        task automatic wait_drained();
                int waited;
                waited = 0;
                while (pending_flits() != 0 && waited < DRAIN_LIMIT) begin
                        @(negedge clk);
                        waited++;
                end
                if (pending_flits() != 0) begin
                        abort_run($sformatf("%0d flits never left the router.", pending_flits()));
                end
        endtask

        always @(negedge clk) begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                        for (int v = 0; v < NUM_VC; v++) begin
                                out_rdy[p][v] = !random_rdy || ($urandom % 4 != 0);
                        end
                end
        end

        // Outputs are combinational, so they are sampled at the edge that pops the flit.
        always @(posedge clk) begin
                expected_t                e;
                noc_router_pkg::vc_id_t   v;
                noc_router_pkg::vc_mask_t exp_full;
                int                       fill;
                if (!reset) begin
                        for (int w = 0; w < NUM_VC; w++) begin
                                if (tail_seen[w] && olck[w]) begin
                                        abort_run($sformatf("VC %0d kept olck after its tail.", w));
                                end
                        end
                        tail_seen = '0;
                        // A flit driven in this cycle enters its buffer only at this edge.
                        for (int w = 0; w < NUM_VC; w++) begin
                                fill = exp_q[w].size();
                                if (in_valid && in_vc == noc_router_pkg::vc_id_t'(w)) begin
                                        fill--;
                                end
                                exp_full[w] = (fill == BUF_DEPTH);
                        end
                        check_full("buf_full", exp_full, buf_full);
                        for (int p = 0; p < NUM_PORTS; p++) begin
                                if (out_flit[p].valid) begin
                                        // The queue whose front matches this flit is its source.
                                        v = out_flit[p].vc;
                                        for (int w = 0; w < NUM_VC; w++) begin
                                                if (exp_q[w].size() != 0 &&
                                                    exp_q[w][0].flit == out_flit[p].flit) begin
                                                        v = noc_router_pkg::vc_id_t'(w);
                                                end
                                        end
                                        if (exp_q[v].size() == 0) begin
                                                abort_run($sformatf("Extra flit on port %0d.", p));
                                        end
                                        e = exp_q[v].pop_front();
                                        check_vc("out_flit.vc", e.vc, out_flit[p].vc);
                                        check_port("out_flit port", e.port,
                                                   noc_router_pkg::port_t'(p));
                                        check_flit("out_flit.flit", e.flit, out_flit[p].flit);
                                        if (!olck[v]) begin
                                                abort_run($sformatf("VC %0d sent with olck low.", v));
                                        end
                                        if (pkt_open[p] && open_vc[p] != v) begin
                                                abort_run($sformatf("Port %0d mixed two packets.", p));
                                        end
                                        pkt_open[p]  = (e.flit.ftype == noc_flit_pkg::head) ||
                                                       (e.flit.ftype == noc_flit_pkg::body);
                                        open_vc[p]   = v;
                                        tail_seen[v] = !pkt_open[p];
                                end
                        end
                end
        end

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles > CYCLE_LIMIT) begin
                        abort_run($sformatf("Timeout: the run did not end in %0d cycles.",
                                            CYCLE_LIMIT));
                end
        end

        initial begin
                noc_router_pkg::vc_id_t vc;
                int                     len;
                void'($urandom(32'h94c7));
                repeat (5) @(negedge clk);
                reset = 1'b0;
                for (int d = 0; d < NUM_SWEEP; d++) begin
                        send_packet(noc_router_pkg::vc_id_t'(d % NUM_VC), 1 + d % 4,
                                    noc_flit_pkg::coord_t'(d / 4), noc_flit_pkg::coord_t'(d % 4));
                end
                random_rdy = 1'b1;
                for (int i = 0; i < NUM_RANDOM; i++) begin
                        send_packet(noc_router_pkg::vc_id_t'($urandom % NUM_VC),
                                    1 + int'($urandom % 4),
                                    noc_flit_pkg::coord_t'($urandom),
                                    noc_flit_pkg::coord_t'($urandom));
                        repeat ($urandom % 3) @(negedge clk);
                end
                wait_drained();
                random_rdy = 1'b0;
                // Every downstream VC is held while a packet waits, then freed.
                for (int i = 0; i < NUM_LOCKED; i++) begin
                        vc      = noc_router_pkg::vc_id_t'($urandom % NUM_VC);
                        // The first locked packet fills its buffer to the top.
                        len     = (i == 0) ? BUF_DEPTH : 1 + int'($urandom % 4);
                        out_lck = '1;
                        send_packet(vc, len, noc_flit_pkg::coord_t'($urandom),
                                    noc_flit_pkg::coord_t'($urandom));
                        repeat (20) @(negedge clk);
                        if (exp_q[vc].size() != len) begin
                                abort_run("A packet crossed the switch while its next VC was locked.");
                        end
                        out_lck = '0;
                        wait_drained();
                end
                repeat (20) @(negedge clk);     // Room for any duplicate flit to show up.
                $display("Test passed");
                $finish;
        end

endmodule

`default_nettype wire

/* filelist.f */
hw/noc_flit_pkg.sv
hw/noc_router_pkg.sv
hw/vc_flit_buffer.sv
hw/xy_route_calc.sv
hw/vc_ctrl.sv
hw/switch_port.sv
hw/router_input_unit.sv
dv/router_input_unit_assertions.sv
dv/router_input_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the design and testbench with Verilator, then run the simulation.
# A failed build or a stop from an assertion is logged as a failure too.
rm -rf obj_dir sim.log
{ verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
        --top-module router_input_unit_tb -f filelist.f -o router_sim \
        && ./obj_dir/router_sim; } > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
